// File: ice51.f
common/ice51_pkg.sv
core/ice51_decode.sv
core/ice51_execute.sv
core/ice51_branch.sv
uart/ice51_uart_tx.sv
src/ice51.sv
verification/ice51_tb_assert.sv
verification/ice51_tb.sv

// File: verification/ice51_tb.sv
`timescale 1ns/1ns

module ice51_tb
   import ice51_pkg::*;
();
   localparam int CLKS_PER_BIT = 8;

   logic        clk;
   logic        nrst;
   code_addr_t  code_addr;
   byte_t       code_data;
   logic        uart_tx;
   byte_t       rom [512];
   byte_t       exp_bytes [256];  // expected uart bytes in send order
   int          exp_cnt;
   int          pc;
   int          prog_len;
   int          assert_errs;
   int          cycles;
   logic [15:0] lfsr;
   byte_t       m_acc;            // reference model state
   logic        m_c;
   byte_t       m_r [8];

   ice51 #(.CLKS_PER_BIT(CLKS_PER_BIT), .RESET_PC(0)) ice51_i (
      .i_clk(clk), .i_nrst(nrst), .o_code_addr(code_addr),
      .i_code_data(code_data), .o_uart_tx(uart_tx)
   );

   bind ice51 ice51_tb_assert #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_assert (
      .i_clk(i_clk), .i_nrst(i_nrst), .i_uart_tx(o_uart_tx), .i_code_addr(o_code_addr)
   );

   assign code_data = rom[code_addr];  // combinational code rom

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   always @(posedge clk) cycles <= cycles + 1;

   ////////////////////////////////////////
   // stimulus values

   // x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   function automatic byte_t take_bits(input int n);
      byte_t r;
      r = 8'h00;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         r    = {r[6:0], lfsr[0]};
      end
      return r;
   endfunction

   ////////////////////////////////////////
   // assembler and reference model

   task automatic emit(input byte_t b);
      rom[pc] = b;
      pc      = pc + 1;
   endtask

   task automatic push(input byte_t b);
      exp_bytes[exp_cnt] = b;
      exp_cnt            = exp_cnt + 1;
   endtask

   task automatic model(input byte_t op, input byte_t imm);
      reg_idx_t n;
      n = op[2:0];
      case (op)
         OP_MOVAI:  m_acc = imm;
         OP_ADDAI:  m_acc = m_acc + imm;
         OP_SUBBAI: {m_c, m_acc} = {1'b0, m_acc} - {1'b0, imm} - m_c;  // borrow out
         OP_XRLAI:  m_acc = m_acc ^ imm;
         OP_DECA:   m_acc = m_acc - 8'd1;
         OP_CLRA:   m_acc = 8'h00;
         OP_CLRC:   m_c = 1'b0;
         default: begin
            case (op & 8'hF8)
               OP_MOVRI_BASE:  m_r[n] = imm;
               OP_INCR_BASE:   m_r[n] = m_r[n] + 8'd1;
               OP_MOVAR_BASE:  m_acc = m_r[n];
               OP_MOVRA_BASE:  m_r[n] = m_acc;
               OP_ADDAR_BASE:  m_acc = m_acc + m_r[n];
               OP_SUBBAR_BASE: {m_c, m_acc} = {1'b0, m_acc} - {1'b0, m_r[n]} - m_c;
               default: ;
            endcase
         end
      endcase
   endtask

   task automatic ins1(input byte_t op);
      emit(op);
      model(op, 8'h00);
   endtask

   task automatic ins2(input byte_t op, input byte_t imm);
      emit(op);
      emit(imm);
      model(op, imm);
   endtask

   // acc parked in r7 while polling busy, 12 bytes
   task automatic send_acc(input bit record);
      byte_t seq [12];
      seq = '{OP_MOVRA_BASE | 8'd7, OP_MOVDPTR, UART_STAT_ADDR[15:8], UART_STAT_ADDR[7:0],
              OP_MOVXAD, OP_JNZ, 8'hFD, OP_MOVDPTR, UART_TX_ADDR[15:8], UART_TX_ADDR[7:0],
              OP_MOVAR_BASE | 8'd7, OP_MOVXDA};
      foreach (seq[i]) emit(seq[i]);
      if (record) push(m_acc);
   endtask

   // jcc skips the 16 byte not-taken block, sjmp skips the 14 byte taken block
   task automatic cond_marker(input byte_t op, input bit taken, input byte_t mk_t,
                              input byte_t mk_n);
      emit(op);
      emit(8'd16);
      emit(OP_MOVAI);
      emit(mk_n);
      send_acc(1'b0);
      emit(OP_SJMP);
      emit(8'd14);
      emit(OP_MOVAI);
      emit(mk_t);
      send_acc(1'b0);
      m_acc = taken ? mk_t : mk_n;
      push(m_acc);
   endtask

   task automatic assemble();
      byte_t n;
      int    loop_pc;
      int    ljmp_pc;
      int    fwd_pc;
      int    l1_pc;
      foreach (rom[a]) rom[a] = byte_t'(a) ^ byte_t'(a >> 8) ^ 8'h5A;
      foreach (m_r[i]) m_r[i] = 8'h00;
      pc      = 0;
      exp_cnt = 0;
      m_acc   = 8'h00;
      m_c     = 1'b0;
      ins2(OP_MOVAI, take_bits(8));
      send_acc(1'b1);
      ins2(OP_ADDAI, take_bits(8));
      send_acc(1'b1);
      ins1(OP_CLRC);
      ins2(OP_SUBBAI, take_bits(8));
      send_acc(1'b1);
      ins2(OP_SUBBAI, take_bits(8));  // borrow in from the previous subb
      send_acc(1'b1);
      // register bank
      for (int r = 0; r < 3; r++) ins2(OP_MOVRI_BASE | byte_t'(r), take_bits(8));
      ins1(OP_INCR_BASE | 8'd1);
      ins1(OP_MOVAR_BASE | 8'd1);
      send_acc(1'b1);
      ins1(OP_ADDAR_BASE | 8'd0);
      send_acc(1'b1);
      ins1(OP_SUBBAR_BASE | 8'd2);
      send_acc(1'b1);
      ins2(OP_XRLAI, take_bits(8));
      send_acc(1'b1);
      ins1(OP_MOVRA_BASE | 8'd3);
      ins1(OP_DECA);
      send_acc(1'b1);
      ins1(OP_MOVAR_BASE | 8'd3);
      send_acc(1'b1);
      ins1(OP_CLRA);
      send_acc(1'b1);
      // countdown, sends n down to 1
      n = take_bits(3) + 8'd2;
      ins2(OP_MOVAI, n);
      loop_pc = pc;
      send_acc(1'b0);
      emit(OP_DECA);
      emit(OP_JNZ);
      emit(byte_t'(loop_pc - pc - 1));
      for (int k = n; k > 0; k--) push(byte_t'(k));
      m_acc = 8'h00;
      cond_marker(OP_JZ, m_acc == 8'h00, 8'hA1, 8'hA0);
      ins2(OP_MOVAI, take_bits(8));
      ins1(OP_CLRC);
      ins2(OP_SUBBAI, take_bits(8));
      cond_marker(OP_JC, m_c, 8'hC1, 8'hC0);
      cond_marker(OP_JNC, !m_c, 8'hD1, 8'hD0);
      cond_marker(OP_JZ, m_acc == 8'h00, 8'hE1, 8'hE0);
      // ljmp forward, backward sjmp, then forward sjmp past both
      emit(OP_LJMP);
      ljmp_pc = pc;
      emit(8'h00);
      emit(8'h00);
      l1_pc = pc;
      ins2(OP_MOVAI, 8'hB1);
      send_acc(1'b0);
      emit(OP_SJMP);
      fwd_pc = pc;
      emit(8'h00);
      rom[ljmp_pc]     = byte_t'(pc >> 8);
      rom[ljmp_pc + 1] = byte_t'(pc);
      ins2(OP_MOVAI, 8'hB0);
      send_acc(1'b0);
      emit(OP_SJMP);
      emit(byte_t'(l1_pc - pc - 1));
      rom[fwd_pc] = byte_t'(pc - fwd_pc - 1);
      push(8'hB0);
      push(8'hB1);
      emit(OP_SJMP);
      emit(8'hFE);  // park here
      prog_len = pc;
   endtask

   ////////////////////////////////////////
   // run

   initial begin
      int limit;
      int timeout_errs;
      nrst         = 1'b0;
      cycles       = 0;
      assert_errs  = 0;
      timeout_errs = 0;
      lfsr         = 16'd18329;
      assemble();
      limit = exp_cnt * (10 * CLKS_PER_BIT + 40) + 500;
      repeat (16) @(posedge clk);
      #5 nrst = 1'b1;
      while (ice51_i.u_assert.frame_cnt < exp_cnt && cycles < limit) @(posedge clk);
      if (ice51_i.u_assert.frame_cnt < exp_cnt) begin
         timeout_errs = 1;
         $display("timeout: not all UART frames received");
      end else begin
         repeat (30 * CLKS_PER_BIT) @(posedge clk);  // line must stay quiet
      end
      $display("errors: %0d (assertions %0d, timeout %0d), frames: %0d of %0d",
               assert_errs + timeout_errs, assert_errs, timeout_errs,
               ice51_i.u_assert.frame_cnt, exp_cnt);
      if (assert_errs + timeout_errs == 0)
         $display("Testbench passed");
      else
         $display("Testbench failed");
      $finish;
   end

endmodule

// File: verification/ice51_tb_assert.sv
`timescale 1ns/1ns

module ice51_tb_assert
   import ice51_pkg::*;
#(
   parameter int CLKS_PER_BIT = 8
) (
   input logic       i_clk,
   input logic       i_nrst,
   input logic       i_uart_tx,
   input code_addr_t i_code_addr
);
   localparam int FRAME_CLKS = 10 * CLKS_PER_BIT;

   logic  in_frame;
   int    pos;        // sample index inside the frame
   byte_t rx_byte;
   int    frame_cnt;
   logic  frame_end;

   assign frame_end = in_frame && (pos == FRAME_CLKS - 1);

   ////////////////////////////////////////
   // frame decoder, one sample per clock

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         in_frame  <= 1'b0;
         pos       <= 0;
         rx_byte   <= 8'h00;
         frame_cnt <= 0;
      end else if (!in_frame) begin
         if (!i_uart_tx) begin
            in_frame <= 1'b1;  // this sample is the first start bit sample
            pos      <= 1;
         end
      end else begin
         // middle of data bits, lsb first
         if (pos % CLKS_PER_BIT == CLKS_PER_BIT / 2 && pos > CLKS_PER_BIT &&
             pos < 9 * CLKS_PER_BIT)
            rx_byte <= {i_uart_tx, rx_byte[7:1]};
         pos <= pos + 1;
         if (frame_end) begin
            in_frame  <= 1'b0;
            frame_cnt <= frame_cnt + 1;
         end
      end
   end

   ////////////////////////////////////////
   // checks

   idle_in_reset: assert property (@(posedge i_clk) !i_nrst |-> i_uart_tx)
      else begin
         $error("o_uart_tx went low while in reset");
         ice51_tb.assert_errs = ice51_tb.assert_errs + 1;
      end

   start_bit_low: assert property (@(posedge i_clk) disable iff (!i_nrst)
      (in_frame && pos < CLKS_PER_BIT) |-> !i_uart_tx)
      else begin
         $error("start bit shorter than one bit period");
         ice51_tb.assert_errs = ice51_tb.assert_errs + 1;
      end

   stop_bit_high: assert property (@(posedge i_clk) disable iff (!i_nrst)
      (in_frame && pos >= 9 * CLKS_PER_BIT) |-> i_uart_tx)
      else begin
         $error("stop bit not high for a full bit period");
         ice51_tb.assert_errs = ice51_tb.assert_errs + 1;
      end

   byte_matches: assert property (@(posedge i_clk) disable iff (!i_nrst)
      frame_end |-> (rx_byte == ice51_tb.exp_bytes[frame_cnt]))
      else begin
         $error("[ERROR] o_uart_tx byte %0d: got %h expected %h", $sampled(frame_cnt),
                $sampled(rx_byte), ice51_tb.exp_bytes[$sampled(frame_cnt)]);
         ice51_tb.assert_errs = ice51_tb.assert_errs + 1;
      end

   no_extra_frame: assert property (@(posedge i_clk) disable iff (!i_nrst)
      (!in_frame && !i_uart_tx) |-> (frame_cnt < ice51_tb.exp_cnt))
      else begin
         $error("a frame started after the last expected byte");
         ice51_tb.assert_errs = ice51_tb.assert_errs + 1;
      end

   // pc sits one past the last byte while the final sjmp executes
   addr_in_program: assert property (@(posedge i_clk) disable iff (!i_nrst)
      i_code_addr <= ice51_tb.prog_len)
      else begin
         $error("code address left the program range");
         ice51_tb.assert_errs = ice51_tb.assert_errs + 1;
      end

endmodule

// File: src/ice51.sv
`timescale 1ns/1ns

module ice51
   import ice51_pkg::*;
#(
   parameter int CLKS_PER_BIT = 104,
   parameter int RESET_PC     = 0
) (
   input  logic       i_clk,
   input  logic       i_nrst,
   output code_addr_t o_code_addr,
   input  byte_t      i_code_data,
   output logic       o_uart_tx
);
   logic       pc_inc;
   logic       exec;
   alu_op_e    alu_op;
   branch_e    branch;
   reg_idx_t   reg_idx;
   byte_t      op1;
   byte_t      op2;
   logic       acc_zero;
   logic       carry;
   logic       tx_wr;
   byte_t      tx_data;
   logic       tx_busy;
   code_addr_t pc;

   assign o_code_addr = pc;  // rom is read straight from the pc

   ice51_decode u_decode (
      .i_clk(i_clk), .i_nrst(i_nrst), .i_code_data(i_code_data),
      .o_pc_inc(pc_inc), .o_exec(exec), .o_alu_op(alu_op), .o_branch(branch),
      .o_reg_idx(reg_idx), .o_op1(op1), .o_op2(op2)
   );

   ice51_execute u_execute (
      .i_clk(i_clk), .i_nrst(i_nrst), .i_exec(exec), .i_alu_op(alu_op),
      .i_reg_idx(reg_idx), .i_op1(op1), .i_op2(op2), .i_tx_busy(tx_busy),
      .o_acc_zero(acc_zero), .o_carry(carry), .o_tx_wr(tx_wr), .o_tx_data(tx_data)
   );

   ice51_branch #(.RESET_PC(RESET_PC)) u_branch (
      .i_clk(i_clk), .i_nrst(i_nrst), .i_pc_inc(pc_inc), .i_exec(exec),
      .i_branch(branch), .i_op1(op1), .i_op2(op2), .i_acc_zero(acc_zero),
      .i_carry(carry), .o_pc(pc)
   );

   ice51_uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart_tx (
      .i_clk(i_clk), .i_nrst(i_nrst), .i_wr(tx_wr), .i_data(tx_data),
      .o_busy(tx_busy), .o_tx(o_uart_tx)
   );

endmodule

// File: uart/ice51_uart_tx.sv
`timescale 1ns/1ns

module ice51_uart_tx
   import ice51_pkg::*;
#(
   parameter int CLKS_PER_BIT = 104
) (
   input  logic  i_clk,
   input  logic  i_nrst,
   input  logic  i_wr,
   input  byte_t i_data,
   output logic  o_busy,
   output logic  o_tx
);
   localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
   localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CLKS_PER_BIT - 1);

   uart_state_e      state, state_nxt;
   logic [CNT_W-1:0] clk_cnt;
   logic [2:0]       bit_cnt;  // data bit index
   byte_t            shift;
   logic             bit_end;

   assign bit_end = (clk_cnt == CNT_LAST);

   ////////////////////////////////////////
   // frame sequencing

   always_comb begin
      state_nxt = state;
      case (state)
         UART_IDLE:  if (i_wr) state_nxt = UART_START;  // writes while busy are lost
         UART_START: if (bit_end) state_nxt = UART_DATA;
         UART_DATA:  if (bit_end && bit_cnt == 3'd7) state_nxt = UART_STOP;
         UART_STOP:  if (bit_end) state_nxt = UART_IDLE;
         default:    state_nxt = UART_IDLE;
      endcase
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state   <= UART_IDLE;
         clk_cnt <= '0;
         bit_cnt <= 3'd0;
      end else begin
         state <= state_nxt;
         // bit period restarts with every bit
         if (state == UART_IDLE || bit_end) clk_cnt <= '0;
         else                                clk_cnt <= clk_cnt + 1'b1;
         if (state == UART_DATA && bit_end) bit_cnt <= bit_cnt + 3'd1;
         else if (state == UART_IDLE)       bit_cnt <= 3'd0;
      end
   end

   // lsb first
   always_ff @(posedge i_clk) begin
      if (state == UART_IDLE && i_wr)       shift <= i_data;
      else if (state == UART_DATA && bit_end) shift <= {1'b1, shift[7:1]};
   end

   ////////////////////////////////////////
   // line and status

   always_comb begin
      case (state)
         UART_START: o_tx = 1'b0;
         UART_DATA:  o_tx = shift[0];
         default:    o_tx = 1'b1;  // idle and stop
      endcase
   end

   assign o_busy = (state != UART_IDLE);

endmodule

// File: core/ice51_branch.sv
`timescale 1ns/1ns

module ice51_branch
   import ice51_pkg::*;
#(
   parameter int RESET_PC = 0
) (
   input  logic       i_clk,
   input  logic       i_nrst,
   input  logic       i_pc_inc,
   input  logic       i_exec,
   input  branch_e    i_branch,
   input  byte_t      i_op1,
   input  byte_t      i_op2,
   input  logic       i_acc_zero,
   input  logic       i_carry,
   output code_addr_t o_pc
);
   code_addr_t pc, pc_nxt;
   code_addr_t rel_target;
   code_addr_t abs_target;
   dptr_t      abs_full;
   logic       cond;
   logic       taken;

   ////////////////////////////////////////
   // targets

   // pc already points past the instruction in EXECUTE
   assign rel_target = pc + {i_op1[7], i_op1};
   assign abs_full   = {i_op1, i_op2};
   assign abs_target = abs_full[8:0];  // upper bits outside code space

   always_comb begin
      case (i_branch)
         BR_SJMP, BR_LJMP: cond = 1'b1;
         BR_JZ:            cond = i_acc_zero;
         BR_JNZ:           cond = ~i_acc_zero;
         BR_JC:            cond = i_carry;
         BR_JNC:           cond = ~i_carry;
         default:          cond = 1'b0;
      endcase
   end

   assign taken = i_exec & cond;

   always_comb begin
      pc_nxt = pc;
      if (taken)         pc_nxt = (i_branch == BR_LJMP) ? abs_target : rel_target;
      else if (i_pc_inc) pc_nxt = pc + 9'd1;
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) pc <= code_addr_t'(RESET_PC);
      else         pc <= pc_nxt;
   end

   assign o_pc = pc;

endmodule

// File: core/ice51_execute.sv
`timescale 1ns/1ns

module ice51_execute
   import ice51_pkg::*;
(
   input  logic     i_clk,
   input  logic     i_nrst,
   input  logic     i_exec,
   input  alu_op_e  i_alu_op,
   input  reg_idx_t i_reg_idx,
   input  byte_t    i_op1,
   input  byte_t    i_op2,
   input  logic     i_tx_busy,
   output logic     o_acc_zero,
   output logic     o_carry,
   output logic     o_tx_wr,
   output byte_t    o_tx_data
);
   byte_t      acc, acc_nxt;
   byte_t      regs [8];
   byte_t      reg_rd;
   byte_t      reg_nxt;
   logic       reg_wr;
   logic       carry, carry_nxt;
   dptr_t      dptr, dptr_nxt;
   byte_t      sub_opnd;
   logic [8:0] sub_full;  // bit 8 is the borrow out
   logic       sel_tx;
   logic       sel_stat;

   assign reg_rd = regs[i_reg_idx];

   ////////////////////////////////////////
   // io decode

   assign sel_tx   = (dptr == UART_TX_ADDR);
   assign sel_stat = (dptr == UART_STAT_ADDR);

   assign o_tx_wr   = i_exec & (i_alu_op == ALU_MOVX_WR) & sel_tx;
   assign o_tx_data = acc;

   ////////////////////////////////////////
   // alu

   // borrow in comes from carry
   assign sub_opnd = (i_alu_op == ALU_SUBB_REG) ? reg_rd : i_op1;
   assign sub_full = {1'b0, acc} - {1'b0, sub_opnd} - {8'd0, carry};

   always_comb begin
      acc_nxt   = acc;
      carry_nxt = carry;
      dptr_nxt  = dptr;
      reg_nxt   = reg_rd;
      reg_wr    = 1'b0;
      case (i_alu_op)
         ALU_MOV_IMM:  acc_nxt = i_op1;
         ALU_ADD_IMM:  acc_nxt = acc + i_op1;  // carry untouched
         ALU_ADD_REG:  acc_nxt = acc + reg_rd;
         ALU_SUBB_IMM,
         ALU_SUBB_REG: begin
            acc_nxt   = sub_full[7:0];
            carry_nxt = sub_full[8];
         end
         ALU_XRL_IMM:  acc_nxt = acc ^ i_op1;
         ALU_INC_REG: begin
            reg_nxt = reg_rd + 8'd1;
            reg_wr  = 1'b1;
         end
         ALU_MOV_REG_IMM: begin
            reg_nxt = i_op1;
            reg_wr  = 1'b1;
         end
         ALU_MOV_REG_ACC: begin
            reg_nxt = acc;
            reg_wr  = 1'b1;
         end
         ALU_MOV_ACC_REG: acc_nxt = reg_rd;
         ALU_CLR_ACC:  acc_nxt = 8'h00;
         ALU_DEC_ACC:  acc_nxt = acc - 8'd1;
         ALU_CLR_C:    carry_nxt = 1'b0;
         ALU_MOV_DPTR: dptr_nxt = {i_op1, i_op2};  // op1 is dph
         ALU_MOVX_RD: begin
            if (sel_stat) acc_nxt = {7'd0, i_tx_busy};
         end
         default: ;  // nop, movx write handled by io decode
      endcase
   end

   ////////////////////////////////////////
   // architectural state

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         acc   <= 8'h00;
         carry <= 1'b0;
         dptr  <= 16'h0000;
      end else if (i_exec) begin
         acc   <= acc_nxt;
         carry <= carry_nxt;
         dptr  <= dptr_nxt;
      end
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         for (int i = 0; i < 8; i++) regs[i] <= 8'h00;
      end else if (i_exec && reg_wr) begin
         regs[i_reg_idx] <= reg_nxt;
      end
   end

   assign o_acc_zero = (acc == 8'h00);
   assign o_carry    = carry;

endmodule

// File: core/ice51_decode.sv
`timescale 1ns/1ns

module ice51_decode
   import ice51_pkg::*;
(
   input  logic     i_clk,
   input  logic     i_nrst,
   input  byte_t    i_code_data,
   output logic     o_pc_inc,
   output logic     o_exec,
   output alu_op_e  o_alu_op,
   output branch_e  o_branch,
   output reg_idx_t o_reg_idx,
   output byte_t    o_op1,
   output byte_t    o_op2
);
   cpu_state_e state, state_nxt;
   byte_t      opcode;
   byte_t      op1_q;
   byte_t      op2_q;
   logic [1:0] ins_len;  // bytes incl. opcode

   ////////////////////////////////////////
   // sequencer

   always_comb begin
      case (state)
         ST_FETCH:   state_nxt = ST_DECODE0;
         ST_DECODE0: state_nxt = (ins_len > 2'd1) ? ST_DECODE1 : ST_EXECUTE;
         ST_DECODE1: state_nxt = (ins_len == 2'd3) ? ST_DECODE2 : ST_EXECUTE;
         ST_DECODE2: state_nxt = ST_EXECUTE;
         default:    state_nxt = ST_FETCH;
      endcase
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) state <= ST_FETCH;
      else         state <= state_nxt;
   end

   // one pulse per consumed code byte
   assign o_pc_inc = (state == ST_FETCH) | (state == ST_DECODE1) | (state == ST_DECODE2);
   assign o_exec   = (state == ST_EXECUTE);

   ////////////////////////////////////////
   // opcode and operand latches

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst)                opcode <= 8'h00;
      else if (state == ST_FETCH) opcode <= i_code_data;  // valid from DECODE0 on
   end

   always_ff @(posedge i_clk) begin
      if (state == ST_DECODE1) op1_q <= i_code_data;
      if (state == ST_DECODE2) op2_q <= i_code_data;
   end

   assign o_op1     = op1_q;
   assign o_op2     = op2_q;
   assign o_reg_idx = opcode[2:0];

   ////////////////////////////////////////
   // classification

   always_comb begin
      o_alu_op = ALU_NONE;
      o_branch = BR_NONE;
      ins_len  = 2'd1;  // unknown opcodes fall through as 1 byte
      case (opcode)
         OP_MOVAI:    begin o_alu_op = ALU_MOV_IMM;  ins_len = 2'd2; end
         OP_ADDAI:    begin o_alu_op = ALU_ADD_IMM;  ins_len = 2'd2; end
         OP_SUBBAI:   begin o_alu_op = ALU_SUBB_IMM; ins_len = 2'd2; end
         OP_XRLAI:    begin o_alu_op = ALU_XRL_IMM;  ins_len = 2'd2; end
         OP_DECA:     o_alu_op = ALU_DEC_ACC;
         OP_CLRA:     o_alu_op = ALU_CLR_ACC;
         OP_CLRC:     o_alu_op = ALU_CLR_C;
         OP_MOVXAD:   o_alu_op = ALU_MOVX_RD;
         OP_MOVXDA:   o_alu_op = ALU_MOVX_WR;
         OP_MOVDPTR:  begin o_alu_op = ALU_MOV_DPTR; ins_len = 2'd3; end
         OP_SJMP:     begin o_branch = BR_SJMP; ins_len = 2'd2; end
         OP_JZ:       begin o_branch = BR_JZ;   ins_len = 2'd2; end
         OP_JNZ:      begin o_branch = BR_JNZ;  ins_len = 2'd2; end
         OP_JC:       begin o_branch = BR_JC;   ins_len = 2'd2; end
         OP_JNC:      begin o_branch = BR_JNC;  ins_len = 2'd2; end
         OP_LJMP:     begin o_branch = BR_LJMP; ins_len = 2'd3; end
         default: begin
            // rn forms, match on top 5 bits
            case (opcode[7:3])
               OP_INCR_BASE[7:3]:   o_alu_op = ALU_INC_REG;
               OP_ADDAR_BASE[7:3]:  o_alu_op = ALU_ADD_REG;
               OP_SUBBAR_BASE[7:3]: o_alu_op = ALU_SUBB_REG;
               OP_MOVAR_BASE[7:3]:  o_alu_op = ALU_MOV_ACC_REG;
               OP_MOVRA_BASE[7:3]:  o_alu_op = ALU_MOV_REG_ACC;
               OP_MOVRI_BASE[7:3]: begin
                  o_alu_op = ALU_MOV_REG_IMM;
                  ins_len  = 2'd2;
               end
               default: o_alu_op = ALU_NONE;
            endcase
         end
      endcase
   end

endmodule

// File: common/ice51_pkg.sv
package ice51_pkg;

   ////////////////////////////////////////
   // widths

   typedef logic [7:0]  byte_t;       // data byte
   typedef logic [8:0]  code_addr_t;  // 512 byte code space
   typedef logic [15:0] dptr_t;
   typedef logic [2:0]  reg_idx_t;    // r0..r7

   ////////////////////////////////////////
   // state machines and decoded ops

   typedef enum logic [2:0] {
      ST_FETCH, ST_DECODE0, ST_DECODE1, ST_DECODE2, ST_EXECUTE
   } cpu_state_e;

   typedef enum logic [4:0] {
      ALU_NONE, ALU_MOV_IMM, ALU_ADD_IMM, ALU_ADD_REG, ALU_SUBB_IMM, ALU_SUBB_REG,
      ALU_XRL_IMM, ALU_INC_REG, ALU_MOV_REG_IMM, ALU_MOV_REG_ACC, ALU_MOV_ACC_REG,
      ALU_CLR_ACC, ALU_DEC_ACC, ALU_CLR_C, ALU_MOV_DPTR, ALU_MOVX_WR, ALU_MOVX_RD
   } alu_op_e;

   typedef enum logic [2:0] {
      BR_NONE, BR_SJMP, BR_JZ, BR_JNZ, BR_JC, BR_JNC, BR_LJMP
   } branch_e;

   typedef enum logic [1:0] {
      UART_IDLE, UART_START, UART_DATA, UART_STOP
   } uart_state_e;

   ////////////////////////////////////////
   // opcodes, register forms keep rn in [2:0]

   localparam byte_t OP_LJMP        = 8'h02;  // ljmp addr16
   localparam byte_t OP_INCR_BASE   = 8'h08;  // inc rn
   localparam byte_t OP_DECA        = 8'h14;
   localparam byte_t OP_ADDAI       = 8'h24;
   localparam byte_t OP_ADDAR_BASE  = 8'h28;
   localparam byte_t OP_JC          = 8'h40;
   localparam byte_t OP_JNC         = 8'h50;
   localparam byte_t OP_JZ          = 8'h60;
   localparam byte_t OP_XRLAI       = 8'h64;
   localparam byte_t OP_JNZ         = 8'h70;
   localparam byte_t OP_MOVAI       = 8'h74;
   localparam byte_t OP_MOVRI_BASE  = 8'h78;  // mov rn,#imm
   localparam byte_t OP_SJMP        = 8'h80;
   localparam byte_t OP_MOVDPTR     = 8'h90;  // high byte first
   localparam byte_t OP_SUBBAI      = 8'h94;
   localparam byte_t OP_SUBBAR_BASE = 8'h98;
   localparam byte_t OP_CLRC        = 8'hC3;
   localparam byte_t OP_MOVXAD      = 8'hE0;  // movx a,@dptr
   localparam byte_t OP_CLRA        = 8'hE4;
   localparam byte_t OP_MOVAR_BASE  = 8'hE8;
   localparam byte_t OP_MOVXDA      = 8'hF0;  // movx @dptr,a
   localparam byte_t OP_MOVRA_BASE  = 8'hF8;

   // io ports seen through dptr
   localparam dptr_t UART_STAT_ADDR = 16'h0200;
   localparam dptr_t UART_TX_ADDR   = 16'h0201;

endpackage
